// File: common/dso_param_pkg.sv
package dso_param_pkg;

  // **************************************************************************
  // screen geometry
  // **************************************************************************
  localparam int ADDR_WIDTH  = 10;              // in-bank address bits
  localparam int HORIZONTAL  = 640;             // samples per screen line
  localparam int HALF_SCREEN = HORIZONTAL / 2;  // pre-trigger depth

  // **************************************************************************
  // sample and address path types
  // **************************************************************************
  typedef logic [7:0]            sample_t;      // adc sample / pixel value
  typedef logic [ADDR_WIDTH-1:0] addr_t;        // address inside one bank
  typedef logic [ADDR_WIDTH:0]   shift_t;       // msb set = shift right
  typedef logic [7:0]            rate_t;        // decimation rate

  localparam sample_t OUT_OF_RANGE_CODE = 8'd255;  // off-window pixel

endpackage

// File: common/dso_ctrl_pkg.sv
package dso_ctrl_pkg;

  // capture sequence of one screen
  typedef enum logic [1:0] {
    pre_fill,   // filling the pre-trigger half
    armed,      // waiting for the trigger strobe
    post_fill,  // filling the post-trigger half
    done        // screen complete, writes stopped
  } cap_state_t;

  // pixel scan over one screen line
  typedef enum logic {
    idle,
    run
  } scan_state_t;

endpackage

// File: verilog/sample_decimator.sv
module sample_decimator import dso_param_pkg::*; (
  input  logic    ad_clk,
  input  logic    rstn,
  input  sample_t ad_data,
  input  rate_t   deci_rate,
  output sample_t deci_data,
  output logic    deci_valid
);

  rate_t rate_cnt;  // cycles since last strobe

  // strobe once every deci_rate+1 cycles
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      rate_cnt   <= '0;
      deci_valid <= 1'b0;
    end else if (rate_cnt >= deci_rate) begin  // >= copes with a rate lowered on the fly
      rate_cnt   <= '0;
      deci_valid <= 1'b1;
    end else begin
      rate_cnt   <= rate_cnt + 1'b1;
      deci_valid <= 1'b0;
    end
  end

  // sample register, aligned with the strobe
  always_ff @(posedge ad_clk) begin
    deci_data <= ad_data;
  end

endmodule

// File: data_store/trig_detect.sv
module trig_detect import dso_param_pkg::*; (
  input  logic    ad_clk,
  input  logic    rstn,
  input  sample_t deci_data,
  input  logic    deci_valid,
  input  sample_t trig_level,
  input  logic    trig_edge,
  output logic    trig_pulse
);

  sample_t hist0;  // newest
  sample_t hist1;
  sample_t hist2;
  sample_t hist3;  // oldest

  logic rise_hit;
  logic fall_hit;

  // history advances on decimated samples only
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      hist0 <= '0;
      hist1 <= '0;
      hist2 <= '0;
      hist3 <= '0;
    end else if (deci_valid) begin
      hist0 <= deci_data;
      hist1 <= hist0;
      hist2 <= hist1;
      hist3 <= hist2;
    end
  end

  // two samples on each side of the level, so one noisy sample cannot fire
  assign rise_hit = (hist3 < trig_level) && (hist2 < trig_level) &&
                    (hist1 >= trig_level) && (hist0 > trig_level);
  assign fall_hit = (hist3 > trig_level) && (hist2 > trig_level) &&
                    (hist1 <= trig_level) && (hist0 < trig_level);

  assign trig_pulse = trig_edge ? rise_hit : fall_hit;  // 1 = rising edge

endmodule

// File: data_store/dso_ram_2port.sv
module dso_ram_2port import dso_param_pkg::*; (
  input  logic                ad_clk,
  input  logic                wr_en,
  input  logic [ADDR_WIDTH:0] wr_addr,  // bank bit on top
  input  sample_t             wr_data,
  input  logic [ADDR_WIDTH:0] rd_addr,  // bank bit on top
  output sample_t             rd_data
);

  sample_t mem [2][HORIZONTAL];  // ping-pong banks

  always_ff @(posedge ad_clk) begin
    if (wr_en) begin
      mem[wr_addr[ADDR_WIDTH]][wr_addr[ADDR_WIDTH-1:0]] <= wr_data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge ad_clk) begin
    rd_data <= mem[rd_addr[ADDR_WIDTH]][rd_addr[ADDR_WIDTH-1:0]];
  end

endmodule

// File: data_store/data_store.sv
module data_store import dso_param_pkg::*, dso_ctrl_pkg::*; (
  input  logic    ad_clk,
  input  logic    rstn,
  input  sample_t deci_data,
  input  logic    deci_valid,
  input  sample_t trig_level,
  input  logic    trig_edge,
  input  logic    wave_run,
  input  shift_t  h_shift,
  input  logic    bank_swap,
  input  addr_t   wave_rd_addr,
  input  logic    rd_req,
  output sample_t wave_rd_data,
  output logic    outrange,
  output logic    trig_seen,
  output logic    capture_done
);

  typedef logic [ADDR_WIDTH+1:0] rel_t;  // room for sums past two screens

  cap_state_t cap_state;
  addr_t      wr_addr;         // ring write pointer
  addr_t      fill_cnt;        // strobes in the current half
  addr_t      trig_addr;       // trigger position in the write bank
  addr_t      disp_trig_addr;  // trigger position in the displayed bank
  addr_t      trig_next;
  logic       wr_pingpong;     // bank being written
  logic       wr_en;
  logic       trig_pulse;

  logic       right_shift;
  addr_t      shift_mag;
  rel_t       shift_addr;
  rel_t       rel_addr;
  rel_t       rd_offset;
  logic       off_window;

  // **************************************************************************
  // capture control
  // **************************************************************************
  assign wr_en     = deci_valid && wave_run && (cap_state != done);
  assign trig_next = (wr_addr >= addr_t'(HORIZONTAL - 2)) ?
                     wr_addr - addr_t'(HORIZONTAL - 2) : wr_addr + addr_t'(2);

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wr_addr <= '0;
    end else if (wr_en) begin
      wr_addr <= (wr_addr == addr_t'(HORIZONTAL - 1)) ? '0 : wr_addr + 1'b1;  // wrap
    end
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      cap_state <= pre_fill;
      fill_cnt  <= '0;
      trig_addr <= '0;
    end else begin
      unique case (cap_state)
        pre_fill: begin
          if (wr_en) begin
            if (fill_cnt == addr_t'(HALF_SCREEN - 1)) begin
              fill_cnt  <= '0;
              cap_state <= armed;
            end else begin
              fill_cnt <= fill_cnt + 1'b1;
            end
          end
        end
        armed: begin
          if (wr_en && trig_pulse) begin
            trig_addr <= trig_next;  // first qualifying strobe only
            cap_state <= post_fill;
          end
        end
        post_fill: begin
          if (wr_en) begin
            if (fill_cnt == addr_t'(HALF_SCREEN - 1)) begin
              fill_cnt  <= '0;
              cap_state <= done;
            end else begin
              fill_cnt <= fill_cnt + 1'b1;
            end
          end
        end
        done: begin
          if (wave_run) cap_state <= pre_fill;  // rearm for the next screen
        end
        default: cap_state <= pre_fill;
      endcase
    end
  end

  assign trig_seen    = (cap_state == post_fill) || (cap_state == done);
  assign capture_done = (cap_state == done);

  // bank swap, display copy of the trigger address follows the swap
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wr_pingpong    <= 1'b0;
      disp_trig_addr <= '0;
    end else if (bank_swap) begin
      wr_pingpong    <= ~wr_pingpong;
      disp_trig_addr <= trig_addr;
    end
  end

  // **************************************************************************
  // read address mapping
  // **************************************************************************
  assign right_shift = h_shift[ADDR_WIDTH];
  assign shift_mag   = h_shift[ADDR_WIDTH-1:0];
  assign shift_addr  = right_shift ? rel_t'(wave_rd_addr) - rel_t'(shift_mag) :
                                     rel_t'(wave_rd_addr) + rel_t'(shift_mag);
  assign rel_addr    = rel_t'(disp_trig_addr) + shift_addr;

  // trigger sits mid screen, fold back into 0..HORIZONTAL-1
  always_comb begin
    if (rel_addr < rel_t'(HALF_SCREEN)) begin
      rd_offset = rel_addr + rel_t'(HALF_SCREEN);
    end else if (rel_addr > rel_t'(HALF_SCREEN + HORIZONTAL - 1)) begin
      rd_offset = rel_addr - rel_t'(HALF_SCREEN + HORIZONTAL);
    end else begin
      rd_offset = rel_addr - rel_t'(HALF_SCREEN);
    end
  end

  assign off_window = right_shift ? (wave_rd_addr < shift_mag) :
                                    (shift_addr > rel_t'(HORIZONTAL - 1));

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      outrange <= 1'b0;
    end else begin
      outrange <= rd_req && off_window;  // lines up with the ram read data
    end
  end

  // **************************************************************************
  // trigger and sample memory
  // **************************************************************************
  trig_detect i_trig_detect (
    .ad_clk     (ad_clk),
    .rstn       (rstn),
    .deci_data  (deci_data),
    .deci_valid (deci_valid),
    .trig_level (trig_level),
    .trig_edge  (trig_edge),
    .trig_pulse (trig_pulse)
  );

  dso_ram_2port i_dso_ram_2port (
    .ad_clk  (ad_clk),
    .wr_en   (wr_en),
    .wr_addr ({wr_pingpong, wr_addr}),
    .wr_data (deci_data),
    .rd_addr ({~wr_pingpong, rd_offset[ADDR_WIDTH-1:0]}),  // the finished bank
    .rd_data (wave_rd_data)
  );

endmodule

// File: verilog/wave_scan.sv
module wave_scan import dso_param_pkg::*, dso_ctrl_pkg::*; (
  input  logic    ad_clk,
  input  logic    rstn,
  input  logic    scan_start,
  input  sample_t wave_rd_data,
  input  logic    outrange,
  output logic    bank_swap,
  output addr_t   wave_rd_addr,
  output logic    rd_req,
  output logic    pixel_valid,
  output sample_t pixel_data,
  output logic    pixel_outrange
);

  scan_state_t scan_state;
  addr_t       pix_addr;  // pixel column being read

  // start pulse only counts while idle
  assign bank_swap = (scan_state == idle) && scan_start;

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      scan_state <= idle;
      pix_addr   <= '0;
    end else begin
      unique case (scan_state)
        idle: begin
          if (scan_start) begin
            scan_state <= run;
            pix_addr   <= '0;
          end
        end
        run: begin
          if (pix_addr == addr_t'(HORIZONTAL - 1)) begin
            scan_state <= idle;  // line complete
          end else begin
            pix_addr <= pix_addr + 1'b1;
          end
        end
        default: scan_state <= idle;
      endcase
    end
  end

  assign rd_req       = (scan_state == run);
  assign wave_rd_addr = pix_addr;

  // read data returns one cycle after the request
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= rd_req;
    end
  end

  assign pixel_data     = outrange ? OUT_OF_RANGE_CODE : wave_rd_data;
  assign pixel_outrange = outrange;

endmodule

// File: verilog/dso_capture_top.sv
module dso_capture_top import dso_param_pkg::*; (
  input  logic    ad_clk,
  input  logic    rstn,
  input  sample_t ad_data,
  input  rate_t   deci_rate,
  input  sample_t trig_level,
  input  logic    trig_edge,     // 1 = rising
  input  logic    wave_run,
  input  shift_t  h_shift,
  input  logic    scan_start,
  output logic    pixel_valid,
  output sample_t pixel_data,
  output logic    pixel_outrange,
  output logic    trig_seen,
  output logic    capture_done
);

  sample_t deci_data;
  logic    deci_valid;
  logic    bank_swap;
  addr_t   wave_rd_addr;
  logic    rd_req;
  sample_t wave_rd_data;
  logic    outrange;

  sample_decimator i_sample_decimator (
    .ad_clk     (ad_clk),
    .rstn       (rstn),
    .ad_data    (ad_data),
    .deci_rate  (deci_rate),
    .deci_data  (deci_data),
    .deci_valid (deci_valid)
  );

  data_store i_data_store (
    .ad_clk       (ad_clk),
    .rstn         (rstn),
    .deci_data    (deci_data),
    .deci_valid   (deci_valid),
    .trig_level   (trig_level),
    .trig_edge    (trig_edge),
    .wave_run     (wave_run),
    .h_shift      (h_shift),
    .bank_swap    (bank_swap),
    .wave_rd_addr (wave_rd_addr),
    .rd_req       (rd_req),
    .wave_rd_data (wave_rd_data),
    .outrange     (outrange),
    .trig_seen    (trig_seen),
    .capture_done (capture_done)
  );

  wave_scan i_wave_scan (
    .ad_clk         (ad_clk),
    .rstn           (rstn),
    .scan_start     (scan_start),
    .wave_rd_data   (wave_rd_data),
    .outrange       (outrange),
    .bank_swap      (bank_swap),
    .wave_rd_addr   (wave_rd_addr),
    .rd_req         (rd_req),
    .pixel_valid    (pixel_valid),
    .pixel_data     (pixel_data),
    .pixel_outrange (pixel_outrange)
  );

endmodule

// File: testbench/dso_capture_sva.sv
module dso_capture_sva import dso_param_pkg::*; (
  input logic    ad_clk,
  input logic    rstn,
  input rate_t   deci_rate,
  input shift_t  h_shift,
  input logic    trig_edge,
  input logic    scan_start,
  input logic    deci_valid,
  input sample_t deci_data,
  input logic    pixel_valid,
  input sample_t pixel_data,
  input logic    pixel_outrange,
  input logic    trig_seen,
  input logic    capture_done
);

  timeunit 1ns;
  timeprecision 100ps;

  int      fail_cnt = 0;  // read by the testbench per test
  logic    scan_seen;     // a scan_start since reset
  logic    strobe_seen;   // a decimated sample since reset
  logic    down_seen;     // decimated stream stepped downward
  sample_t last_strobe;
  int      run_cnt;       // pixel index inside the current line
  logic    prev_in;       // previous pixel valid and in the window
  sample_t prev_data;
  int      offset;        // window position of the current pixel
  logic    exp_out;
  sample_t exp_step;

  // window position from the pixel index and the signed shift
  always_comb begin
    offset   = h_shift[ADDR_WIDTH] ? run_cnt - int'(h_shift[ADDR_WIDTH-1:0]) :
                                     run_cnt + int'(h_shift[ADDR_WIDTH-1:0]);
    exp_out  = (offset < 0) || (offset > HORIZONTAL - 1);
    exp_step = prev_data + sample_t'(deci_rate) + 8'd1;  // sawtooth step, mod 256
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      scan_seen   <= 1'b0;
      strobe_seen <= 1'b0;
      down_seen   <= 1'b0;
      last_strobe <= '0;
      run_cnt     <= 0;
      prev_in     <= 1'b0;
      prev_data   <= '0;
    end else begin
      if (scan_start) scan_seen <= 1'b1;
      if (deci_valid) begin
        strobe_seen <= 1'b1;
        last_strobe <= deci_data;
        if (deci_data < last_strobe) down_seen <= 1'b1;
      end
      run_cnt   <= pixel_valid ? run_cnt + 1 : 0;
      prev_in   <= pixel_valid && !exp_out;
      prev_data <= pixel_data;
    end
  end

  // ************************************************************************
  // reset and trigger
  // ************************************************************************
  a_idle_pixel: assert property (@(posedge ad_clk) disable iff (!rstn)
    !scan_seen |-> !pixel_valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("pixel_valid went high before any scan_start");
    end

  a_idle_trig: assert property (@(posedge ad_clk) disable iff (!rstn)
    !strobe_seen |-> (!trig_seen && !capture_done))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("trig_seen or capture_done high before the first strobe");
    end

  a_done_after_trig: assert property (@(posedge ad_clk) disable iff (!rstn)
    $rose(capture_done) |-> $past(trig_seen))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("capture_done rose without trig_seen set in the cycle before");
    end

  a_no_fall_trig: assert property (@(posedge ad_clk) disable iff (!rstn)
    (!trig_edge && !down_seen) |-> !trig_seen)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("falling trigger fired on a stream that never went down");
    end

  // ************************************************************************
  // scan line
  // ************************************************************************
  a_line_len: assert property (@(posedge ad_clk) disable iff (!rstn)
    (!pixel_valid && $past(pixel_valid)) |-> (run_cnt == HORIZONTAL))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ERROR %0t pixel_valid run exp %0d got %0d", $time, HORIZONTAL,
             $sampled(run_cnt));
    end

  a_line_max: assert property (@(posedge ad_clk) disable iff (!rstn)
    pixel_valid |-> (run_cnt < HORIZONTAL))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("more than one screen line of pixel_valid in a row");
    end

  a_outrange: assert property (@(posedge ad_clk) disable iff (!rstn)
    pixel_valid |-> (pixel_outrange == exp_out))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ERROR %0t pixel_outrange exp %0b got %0b", $time, $sampled(exp_out),
             $sampled(pixel_outrange));
    end

  a_fill: assert property (@(posedge ad_clk) disable iff (!rstn)
    (pixel_valid && exp_out) |-> (pixel_data == OUT_OF_RANGE_CODE))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ERROR %0t pixel_data exp %0d got %0d", $time, OUT_OF_RANGE_CODE,
             $sampled(pixel_data));
    end

  // last window slot holds the oldest sample of the ring
  a_step: assert property (@(posedge ad_clk) disable iff (!rstn)
    (pixel_valid && prev_in && !exp_out && (offset != HORIZONTAL - 1)) |->
    (pixel_data == exp_step))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ERROR %0t pixel_data exp %0d got %0d", $time, $sampled(exp_step),
             $sampled(pixel_data));
    end

endmodule

bind dso_capture_top dso_capture_sva i_dso_capture_sva (
  .ad_clk         (ad_clk),
  .rstn           (rstn),
  .deci_rate      (deci_rate),
  .h_shift        (h_shift),
  .trig_edge      (trig_edge),
  .scan_start     (scan_start),
  .deci_valid     (deci_valid),
  .deci_data      (deci_data),
  .pixel_valid    (pixel_valid),
  .pixel_data     (pixel_data),
  .pixel_outrange (pixel_outrange),
  .trig_seen      (trig_seen),
  .capture_done   (capture_done)
);

// File: testbench/dso_capture_tb.sv
module dso_capture_tb import dso_param_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int      TIMEOUT_CYCLES = 8 * HORIZONTAL * 4;  // 8 screens at the slowest rate
  localparam sample_t TRIG_LEVEL     = 8'd128;

  logic    ad_clk;
  logic    rstn;
  sample_t ad_data;
  rate_t   deci_rate;
  sample_t trig_level;
  logic    trig_edge;
  logic    wave_run;
  shift_t  h_shift;
  logic    scan_start;
  logic    pixel_valid;
  sample_t pixel_data;
  logic    pixel_outrange;
  logic    trig_seen;
  logic    capture_done;

  int   seed = 32'h8f84_12fc;
  int   cycle_cnt = 0;
  int   tests_run = 0;
  int   fail_mark = 0;
  int   rnd;
  logic clip_ramp;  // ramp stops at full scale
  logic hold_ramp;  // ramp frozen where it is

  always #4 ad_clk = ~ad_clk;

  // adc sawtooth, one step per clock
  always @(posedge ad_clk) begin
    if (!rstn) begin
      ad_data <= '0;
    end else if (hold_ramp || (clip_ramp && ad_data == 8'hff)) begin
      ad_data <= ad_data;
    end else begin
      ad_data <= ad_data + 8'd1;
    end
  end

  always @(posedge ad_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a capture or scan never finished", cycle_cnt);
      $display("Errors found");
      $finish;
    end
  end

  dso_capture_top i_dso_capture_top (
    .ad_clk         (ad_clk),
    .rstn           (rstn),
    .ad_data        (ad_data),
    .deci_rate      (deci_rate),
    .trig_level     (trig_level),
    .trig_edge      (trig_edge),
    .wave_run       (wave_run),
    .h_shift        (h_shift),
    .scan_start     (scan_start),
    .pixel_valid    (pixel_valid),
    .pixel_data     (pixel_data),
    .pixel_outrange (pixel_outrange),
    .trig_seen      (trig_seen),
    .capture_done   (capture_done)
  );

  function automatic int sva_fails();
    return i_dso_capture_top.i_dso_capture_sva.fail_cnt;
  endfunction

  task automatic apply_reset();
    @(posedge ad_clk);
    rstn       <= 1'b0;
    wave_run   <= 1'b0;
    scan_start <= 1'b0;
    repeat (2) @(posedge ad_clk);
    rstn <= 1'b1;
  endtask

  // one full screen, writes stop while capture_done is seen
  task automatic capture_screen(input rate_t rate);
    @(posedge ad_clk);
    deci_rate <= rate;
    repeat (4) @(posedge ad_clk);  // decimator settles on the new rate
    wave_run <= 1'b1;
    do @(negedge ad_clk); while (!capture_done);
    @(posedge ad_clk);
    wave_run <= 1'b0;
  endtask

  task automatic scan_line(input shift_t shift, input logic extra_start);
    @(posedge ad_clk);
    h_shift    <= shift;
    scan_start <= 1'b1;
    @(posedge ad_clk);
    scan_start <= 1'b0;
    do @(negedge ad_clk); while (!pixel_valid);
    if (extra_start) begin
      repeat (100) @(posedge ad_clk);
      scan_start <= 1'b1;  // must be ignored mid line
      @(posedge ad_clk);
      scan_start <= 1'b0;
    end
    do @(negedge ad_clk); while (pixel_valid);
  endtask

  task automatic report_test(input string name);
    tests_run = tests_run + 1;
    $display("test %0d %s: %0d assertion failures", tests_run, name,
             sva_fails() - fail_mark);
    fail_mark = sva_fails();
  endtask

  // ************************************************************************
  // test sequence
  // ************************************************************************
  initial begin
    ad_clk     = 1'b0;
    rstn       = 1'b0;
    ad_data    = '0;
    deci_rate  = '0;
    trig_level = TRIG_LEVEL;
    trig_edge  = 1'b1;
    wave_run   = 1'b0;
    h_shift    = '0;
    scan_start = 1'b0;
    clip_ramp  = 1'b0;
    hold_ramp  = 1'b0;

    apply_reset();
    repeat (20) @(posedge ad_clk);  // outputs must stay quiet
    report_test("reset state");

    rnd = $random(seed);
    capture_screen(rate_t'(rnd & 3));
    scan_line('0, 1'b0);
    report_test("rising trigger capture");

    @(posedge ad_clk);
    trig_edge <= 1'b0;
    clip_ramp <= 1'b1;
    hold_ramp <= 1'b1;
    apply_reset();
    @(posedge ad_clk);
    deci_rate <= '0;
    wave_run  <= 1'b1;
    repeat (HALF_SCREEN + 8) @(posedge ad_clk);  // pre-trigger half full, capture armed
    hold_ramp <= 1'b0;                          // upward crossing falls in the armed state
    repeat (HORIZONTAL) @(posedge ad_clk);
    wave_run  <= 1'b0;
    trig_edge <= 1'b1;
    clip_ramp <= 1'b0;
    apply_reset();
    report_test("falling trigger on rising ramp");

    rnd = $random(seed);
    capture_screen(rate_t'(rnd & 3));
    scan_line('0, 1'b1);
    report_test("zero shift scan with repeated start");

    for (int i = 0; i < 2; i++) begin
      rnd = $random(seed);
      capture_screen(rate_t'(rnd & 3));
      rnd = $random(seed);
      scan_line({rnd[31], addr_t'((rnd & 32'h3ff) % 700)}, 1'b0);
    end
    report_test("random shift scans");

    $display("%0d tests run, %0d assertion failures", tests_run, sva_fails());
    if (sva_fails() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: dso_capture_top.f
common/dso_param_pkg.sv
common/dso_ctrl_pkg.sv
verilog/sample_decimator.sv
data_store/trig_detect.sv
data_store/dso_ram_2port.sv
data_store/data_store.sv
verilog/wave_scan.sv
verilog/dso_capture_top.sv
testbench/dso_capture_sva.sv
testbench/dso_capture_tb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP       = dso_capture_tb
FILE_LIST = dso_capture_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100000

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
